// ==== sd_proto_pkg.sv ====
// SD bus protocol types, command indices, card states, response kinds and status bit positions
package sd_proto_pkg;

   typedef logic [47:0]  cmd_frame_t;
   typedef logic [5:0]   cmd_index_t;
   typedef logic [31:0]  cmd_arg_t;
   typedef logic [15:0]  rca_t;
   typedef logic [31:0]  card_status_t;
   // sent MSB first
   typedef logic [135:0] resp_frame_t;

   typedef enum logic [3:0] {
      CARD_IDLE  = 4'd0,
      CARD_READY = 4'd1,
      CARD_IDENT = 4'd2,
      CARD_STBY  = 4'd3,
      CARD_TRAN  = 4'd4,
      CARD_DATA  = 4'd5,
      CARD_RCV   = 4'd6,
      CARD_PRG   = 4'd7,
      CARD_DIS   = 4'd8,
      CARD_INA   = 4'd9
   } card_state_e;

   // NONE and BAD never reach the PHY
   typedef enum logic [3:0] {
      RESP_NONE = 4'd0,
      RESP_BAD  = 4'd1,
      RESP_R1   = 4'd2,
      RESP_R1B  = 4'd3,
      RESP_R2   = 4'd4,
      RESP_R3   = 4'd5,
      RESP_R6   = 4'd6,
      RESP_R7   = 4'd7
   } resp_kind_e;

   localparam cmd_index_t CMD0_GO_IDLE        = 6'd0;
   localparam cmd_index_t CMD2_ALL_SEND_CID   = 6'd2;
   localparam cmd_index_t CMD3_SEND_REL_ADDR  = 6'd3;
   localparam cmd_index_t CMD7_SEL_CARD       = 6'd7;
   localparam cmd_index_t CMD8_SEND_IF_COND   = 6'd8;
   localparam cmd_index_t CMD9_SEND_CSD       = 6'd9;
   localparam cmd_index_t CMD10_SEND_CID      = 6'd10;
   localparam cmd_index_t CMD13_SEND_STATUS   = 6'd13;
   localparam cmd_index_t CMD15_GO_INACTIVE   = 6'd15;
   localparam cmd_index_t CMD55_APP_CMD       = 6'd55;
   localparam cmd_index_t ACMD41_SEND_OP_COND = 6'd41;

   // card status word bit positions
   localparam int STAT_COM_CRC_ERROR   = 23;
   localparam int STAT_ILLEGAL_COMMAND = 22;
   localparam int STAT_STATE_MSB       = 12;
   localparam int STAT_STATE_LSB       = 9;
   localparam int STAT_READY_FOR_DATA  = 8;
   localparam int STAT_APP_CMD         = 5;

endpackage

// ==== sd_card_pkg.sv ====
// identity registers of the emulated card: CID, CSD and OCR fields
package sd_card_pkg;

   typedef logic [127:0] card_reg_t;
   typedef logic [31:0]  ocr_t;

   // manufacturer, OEM "EM", name "EMUSD", rev 1.0, serial, date, crc/end
   localparam card_reg_t CARD_CID = {
      8'h7E, 16'h454D, 40'h454D555344, 8'h10, 32'h0C0FFEE1,
      4'h0, 12'h0B3, 8'hFF
   };

   // CSD version 2.0, 512 byte blocks
   localparam card_reg_t CARD_CSD = {
      2'b01, 6'h00, 8'h0E, 8'h00, 8'h32, 12'h5B5, 4'h9,
      1'b0, 1'b0, 1'b0, 1'b0, 6'h00,
      22'h003B37, 1'b0,
      1'b1, 7'h7F, 7'h00, 1'b0, 2'b00, 3'b010, 4'h9, 1'b0, 5'h00,
      1'b0, 1'b0, 1'b0, 1'b0, 2'b00, 2'b00,
      8'hFF
   };

   // 2.7 to 3.6 V
   localparam logic [23:0] OCR_VOLTAGE_WINDOW = 24'hFF8000;

   localparam int OCR_POWER_UP_BIT  = 31;
   localparam int OCR_HIGH_CAPACITY = 30;

endpackage

// ==== sd_cmd_capture.sv ====
// command strobe edge detect, CRC gate and command field latch
`timescale 1ns/1ps

module sd_cmd_capture (
   input  logic                     clk_50,
   input  logic                     reset_s,
   input  sd_proto_pkg::cmd_frame_t phy_cmd_in,
   input  logic                     phy_cmd_in_crc_good,
   input  logic                     phy_cmd_in_act,
   input  logic                     accept,
   output logic                     cmd_valid,
   output sd_proto_pkg::cmd_index_t cmd_index,
   output sd_proto_pkg::cmd_arg_t   cmd_arg,
   output logic                     crc_fail
);

   logic act_prev;
   logic take;

   // rising strobe edge while the sequencer is idle
   assign take = phy_cmd_in_act & ~act_prev & accept;

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         act_prev  <= 1'b0;
         cmd_valid <= 1'b0;
         crc_fail  <= 1'b0;
      end else begin
         act_prev  <= phy_cmd_in_act;
         cmd_valid <= take & phy_cmd_in_crc_good;
         crc_fail  <= take & ~phy_cmd_in_crc_good;
      end
   end

   // start and transmission bits and crc7 are not kept
   always_ff @(posedge clk_50) begin
      if (take && phy_cmd_in_crc_good) begin
         cmd_index <= phy_cmd_in[45:40];
         cmd_arg   <= phy_cmd_in[39:8];
      end
   end

endmodule

// ==== sd_card_status.sv ====
// 32-bit card status register
`timescale 1ns/1ps

module sd_card_status (
   input  logic                         clk_50,
   input  logic                         reset_s,
   input  logic                         crc_fail,
   input  logic                         cmd_accepted,
   input  logic                         illegal_set,
   input  logic                         app_set,
   input  logic                         app_clear,
   input  sd_proto_pkg::card_state_e    card_state,
   output sd_proto_pkg::card_status_t   status,
   output logic                         app_cmd
);

   import sd_proto_pkg::*;

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         status                      <= '0;
         status[STAT_READY_FOR_DATA] <= 1'b1;
      end else begin
         // a good command clears the error bits of the previous one
         if (cmd_accepted) begin
            status[STAT_COM_CRC_ERROR]   <= 1'b0;
            status[STAT_ILLEGAL_COMMAND] <= 1'b0;
         end
         if (crc_fail) begin
            status[STAT_COM_CRC_ERROR] <= 1'b1;
         end
         if (illegal_set) begin
            status[STAT_ILLEGAL_COMMAND] <= 1'b1;
         end

         if (app_set) begin
            status[STAT_APP_CMD] <= 1'b1;
         end else if (app_clear) begin
            status[STAT_APP_CMD] <= 1'b0;
         end

         // no data path, so always ready
         status[STAT_READY_FOR_DATA]            <= 1'b1;
         status[STAT_STATE_MSB:STAT_STATE_LSB] <= card_state;
      end
   end

   assign app_cmd = status[STAT_APP_CMD];

endmodule

// ==== sd_card_fsm.sv ====
// command sequencer with card state, RCA, OCR and ACMD41 poll counter
`timescale 1ns/1ps

module sd_card_fsm #(
   parameter int          ACMD41_BUSY_POLLS = 3,
   parameter logic [15:0] RCA_STEP          = 16'h1337
) (
   input  logic                      clk_50,
   input  logic                      reset_s,
   input  logic                      cmd_valid,
   input  sd_proto_pkg::cmd_index_t  cmd_index,
   input  sd_proto_pkg::cmd_arg_t    cmd_arg,
   input  logic                      app_cmd,
   input  logic                      resp_sent,
   output logic                      accept,
   output logic                      cmd_accepted,
   output logic                      illegal_set,
   output logic                      app_set,
   output logic                      app_clear,
   output logic                      resp_start,
   output sd_proto_pkg::resp_kind_e  resp_kind,
   output sd_proto_pkg::card_state_e card_state,
   output sd_proto_pkg::rca_t        rca,
   output sd_card_pkg::ocr_t         ocr,
   output sd_proto_pkg::cmd_arg_t    resp_arg,
   output sd_proto_pkg::cmd_index_t  cmd_in_last,
   output logic                      err_unhandled_cmd
);

   import sd_proto_pkg::*;
   import sd_card_pkg::*;

   // high capacity card, not yet powered up
   localparam ocr_t OCR_RESET = (ocr_t'(1) << OCR_HIGH_CAPACITY) | ocr_t'(OCR_VOLTAGE_WINDOW);

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_DECODE,
      SEQ_UPDATE,
      SEQ_WAIT
   } seq_e;

   seq_e        seq;
   card_state_e card_state_next;
   logic [7:0]  poll_count;
   logic        retry;
   logic        rca_match;
   logic        quiet_done;
   logic        resp_done;
   logic        addressed;

   assign rca_match  = (cmd_arg[31:16] == rca);
   assign addressed  = card_state inside {CARD_STBY, CARD_TRAN, CARD_DATA, CARD_RCV,
                                          CARD_PRG, CARD_DIS};
   assign accept       = (seq == SEQ_IDLE);
   assign cmd_accepted = accept & cmd_valid;
   assign quiet_done   = (seq == SEQ_UPDATE) && (resp_kind inside {RESP_NONE, RESP_BAD});
   assign resp_done    = (seq == SEQ_WAIT) && resp_sent;
   assign illegal_set  = (seq == SEQ_UPDATE) && (resp_kind == RESP_BAD);
   assign app_set      = (seq == SEQ_UPDATE) && (resp_kind == RESP_R1) &&
                         (cmd_index == CMD55_APP_CMD);
   // app mode ends with the command that follows CMD55
   assign app_clear    = (quiet_done || resp_done) && app_cmd && (cmd_index != CMD55_APP_CMD);

   always_ff @(posedge clk_50) begin
      resp_start <= 1'b0;
      if (!reset_s) begin
         seq               <= SEQ_IDLE;
         card_state        <= CARD_IDLE;
         rca               <= '0;
         ocr               <= OCR_RESET;
         poll_count        <= '0;
         retry             <= 1'b0;
         cmd_in_last       <= '0;
         err_unhandled_cmd <= 1'b0;
      end else begin
         case (seq)
            SEQ_IDLE: begin
               retry <= 1'b0;
               if (cmd_valid) begin
                  cmd_in_last <= cmd_index;
                  seq         <= SEQ_DECODE;
               end
            end
            SEQ_DECODE: begin
               seq             <= SEQ_UPDATE;
               card_state_next <= card_state;
               // illegal unless a case below accepts it
               resp_kind       <= RESP_BAD;
               if (app_cmd && !retry) begin
                  case (cmd_index)
                     ACMD41_SEND_OP_COND: begin
                        if (card_state == CARD_IDLE) begin
                           resp_kind <= RESP_R3;
                           // zero voltage window is only a query
                           if (cmd_arg[OCR_HIGH_CAPACITY] && cmd_arg[23:0] != '0) begin
                              if (poll_count >= ACMD41_BUSY_POLLS) begin
                                 ocr[OCR_POWER_UP_BIT] <= 1'b1;
                                 card_state_next       <= CARD_READY;
                              end else begin
                                 poll_count <= poll_count + 8'd1;
                              end
                           end
                        end
                     end
                     default: begin
                        // try the same index again as a plain command
                        retry <= 1'b1;
                        seq   <= SEQ_DECODE;
                     end
                  endcase
               end else begin
                  case (cmd_index)
                     CMD0_GO_IDLE: begin
                        resp_kind <= RESP_NONE;
                        if (card_state != CARD_INA) begin
                           card_state_next <= CARD_IDLE;
                           rca             <= '0;
                           ocr             <= OCR_RESET;
                           poll_count      <= '0;
                        end
                     end
                     CMD2_ALL_SEND_CID: begin
                        if (card_state == CARD_READY) begin
                           resp_kind       <= RESP_R2;
                           card_state_next <= CARD_IDENT;
                        end
                     end
                     CMD3_SEND_REL_ADDR: begin
                        if (card_state inside {CARD_IDENT, CARD_STBY}) begin
                           rca             <= rca + RCA_STEP;
                           resp_kind       <= RESP_R6;
                           card_state_next <= CARD_STBY;
                        end
                     end
                     CMD7_SEL_CARD: begin
                        if (rca_match) begin
                           if (card_state inside {CARD_STBY, CARD_DIS}) begin
                              resp_kind       <= RESP_R1B;
                              card_state_next <= CARD_TRAN;
                           end
                        end else begin
                           // deselect, no response
                           resp_kind <= RESP_NONE;
                           if (card_state inside {CARD_TRAN, CARD_DATA}) begin
                              card_state_next <= CARD_STBY;
                           end else if (card_state == CARD_PRG) begin
                              card_state_next <= CARD_DIS;
                           end
                        end
                     end
                     CMD8_SEND_IF_COND: begin
                        if (card_state == CARD_IDLE) begin
                           resp_kind <= (cmd_arg[11:8] == 4'h1) ? RESP_R7 : RESP_NONE;
                           resp_arg  <= {20'h0, 4'h1, cmd_arg[7:0]};
                        end
                     end
                     CMD9_SEND_CSD, CMD10_SEND_CID: begin
                        if (!rca_match) begin
                           resp_kind <= RESP_NONE;
                        end else if (card_state == CARD_STBY) begin
                           resp_kind <= RESP_R2;
                        end
                     end
                     CMD13_SEND_STATUS: begin
                        if (!rca_match) begin
                           resp_kind <= RESP_NONE;
                        end else if (addressed) begin
                           resp_kind <= RESP_R1;
                        end
                     end
                     CMD15_GO_INACTIVE: begin
                        if (!rca_match) begin
                           resp_kind <= RESP_NONE;
                        end else if (addressed) begin
                           resp_kind       <= RESP_NONE;
                           card_state_next <= CARD_INA;
                        end
                     end
                     CMD55_APP_CMD: begin
                        if (!rca_match) begin
                           resp_kind <= RESP_NONE;
                        end else if (addressed || card_state == CARD_IDLE) begin
                           resp_kind <= RESP_R1;
                        end
                     end
                     default: err_unhandled_cmd <= 1'b1;
                  endcase
               end
            end
            SEQ_UPDATE: begin
               // status word takes illegal and app bits in this cycle
               if (quiet_done) begin
                  card_state <= card_state_next;
                  seq        <= SEQ_IDLE;
               end else begin
                  resp_start <= 1'b1;
                  seq        <= SEQ_WAIT;
               end
            end
            SEQ_WAIT: begin
               if (resp_sent) begin
                  card_state <= card_state_next;
                  seq        <= SEQ_IDLE;
               end
            end
            default: seq <= SEQ_IDLE;
         endcase
      end
   end

endmodule

// ==== sd_resp_builder.sv ====
// response frame packing and the act/done response handshake with the PHY
`timescale 1ns/1ps

module sd_resp_builder (
   input  logic                        clk_50,
   input  logic                        reset_s,
   input  logic                        resp_start,
   input  sd_proto_pkg::resp_kind_e    resp_kind,
   input  sd_proto_pkg::cmd_index_t    cmd_index,
   input  sd_proto_pkg::card_status_t  status,
   input  sd_proto_pkg::rca_t          rca,
   input  sd_card_pkg::ocr_t           ocr,
   input  sd_proto_pkg::cmd_arg_t      resp_arg,
   input  logic                        phy_resp_done,
   output sd_proto_pkg::resp_frame_t   phy_resp_out,
   output logic [3:0]                  phy_resp_type,
   output logic                        phy_resp_act,
   output logic                        resp_sent
);

   import sd_proto_pkg::*;
   import sd_card_pkg::*;

   resp_frame_t frame;
   card_reg_t   ident;
   logic        done_prev;
   logic        armed;

   assign ident = (cmd_index == CMD9_SEND_CSD) ? CARD_CSD : CARD_CID;

   // 48-bit formats sit in the top bits, zero padded below
   always_comb begin
      frame = '0;
      case (resp_kind)
         RESP_R1, RESP_R1B: frame = {2'b00, cmd_index, status, 8'h01, 88'h0};
         RESP_R2:           frame = {2'b00, 6'b111111, ident[127:1], 1'b1};
         RESP_R3:           frame = {2'b00, 6'b111111, ocr, 8'hFF, 88'h0};
         RESP_R6: frame = {2'b00, 6'b000011, rca, status[STAT_COM_CRC_ERROR],
                           status[STAT_ILLEGAL_COMMAND], status[19], status[12:0],
                           8'h01, 88'h0};
         RESP_R7:           frame = {2'b00, 6'b001000, resp_arg, 8'h01, 88'h0};
         default:           frame = '0;
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (resp_start) begin
         phy_resp_out  <= frame;
         phy_resp_type <= resp_kind;
      end
   end

   // act rises one cycle after the frame is held
   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         done_prev    <= 1'b0;
         armed        <= 1'b0;
         phy_resp_act <= 1'b0;
         resp_sent    <= 1'b0;
      end else begin
         done_prev <= phy_resp_done;
         armed     <= resp_start;
         resp_sent <= 1'b0;
         if (armed) begin
            phy_resp_act <= 1'b1;
         end else if (phy_resp_act && phy_resp_done && !done_prev) begin
            phy_resp_act <= 1'b0;
            resp_sent    <= 1'b1;
         end
      end
   end

endmodule

// ==== sd_cmd_link.sv ====
// SD command link top level: capture, card FSM, status register and response builder
`timescale 1ns/1ps

module sd_cmd_link #(
   parameter int          ACMD41_BUSY_POLLS = 3,
   parameter logic [15:0] RCA_STEP          = 16'h1337
) (
   input  logic                      clk_50,
   input  logic                      reset_s,
   input  sd_proto_pkg::cmd_frame_t  phy_cmd_in,
   input  logic                      phy_cmd_in_crc_good,
   input  logic                      phy_cmd_in_act,
   output sd_proto_pkg::resp_frame_t phy_resp_out,
   output logic [3:0]                phy_resp_type,
   output logic                      phy_resp_act,
   input  logic                      phy_resp_done,
   output sd_proto_pkg::card_state_e link_card_state,
   output sd_proto_pkg::cmd_index_t  cmd_in_last,
   output logic                      err_cmd_crc,
   output logic                      err_unhandled_cmd
);

   import sd_proto_pkg::*;
   import sd_card_pkg::*;

   logic         accept;
   logic         cmd_valid;
   logic         crc_fail;
   cmd_index_t   cmd_index;
   cmd_arg_t     cmd_arg;
   logic         cmd_accepted;
   logic         illegal_set;
   logic         app_set;
   logic         app_clear;
   logic         app_cmd;
   card_status_t status;
   logic         resp_start;
   logic         resp_sent;
   resp_kind_e   resp_kind;
   rca_t         rca;
   ocr_t         ocr;
   cmd_arg_t     resp_arg;

   sd_cmd_capture sd_cmd_capture_inst (
      .clk_50, .reset_s, .phy_cmd_in, .phy_cmd_in_crc_good, .phy_cmd_in_act,
      .accept, .cmd_valid, .cmd_index, .cmd_arg, .crc_fail
   );

   sd_card_fsm #(
      .ACMD41_BUSY_POLLS (ACMD41_BUSY_POLLS),
      .RCA_STEP          (RCA_STEP)
   ) sd_card_fsm_inst (
      .clk_50, .reset_s, .cmd_valid, .cmd_index, .cmd_arg, .app_cmd, .resp_sent,
      .accept, .cmd_accepted, .illegal_set, .app_set, .app_clear, .resp_start,
      .resp_kind, .card_state (link_card_state), .rca, .ocr, .resp_arg,
      .cmd_in_last, .err_unhandled_cmd
   );

   sd_card_status sd_card_status_inst (
      .clk_50, .reset_s, .crc_fail, .cmd_accepted, .illegal_set, .app_set,
      .app_clear, .card_state (link_card_state), .status, .app_cmd
   );

   sd_resp_builder sd_resp_builder_inst (
      .clk_50, .reset_s, .resp_start, .resp_kind, .cmd_index, .status, .rca, .ocr,
      .resp_arg, .phy_resp_done, .phy_resp_out, .phy_resp_type, .phy_resp_act,
      .resp_sent
   );

   // sticky until reset
   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         err_cmd_crc <= 1'b0;
      end else if (crc_fail) begin
         err_cmd_crc <= 1'b1;
      end
   end

endmodule

// ==== sd_cmd_link_asserts.sv ====
// concurrent assertions on the PHY response handshake, bound into sd_cmd_link
`timescale 1ns/1ps

module sd_cmd_link_asserts (
   input logic                      clk_50,
   input logic                      reset_s,
   input sd_proto_pkg::resp_frame_t phy_resp_out,
   input logic [3:0]                phy_resp_type,
   input logic                      phy_resp_act,
   input logic                      phy_resp_done
);

   // read by the testbench at the end of the run
   int fail_count = 0;

   assert property (@(posedge clk_50) !reset_s |=> !phy_resp_act)
      else begin
         $error("phy_resp_act not low after reset");
         fail_count++;
      end

   // frame and type held while the PHY is sending
   assert property (@(posedge clk_50) disable iff (!reset_s)
                    phy_resp_act && $past(phy_resp_act) |->
                    $stable(phy_resp_out) && $stable(phy_resp_type))
      else begin
         $error("response frame changed while phy_resp_act high");
         fail_count++;
      end

   assert property (@(posedge clk_50) disable iff (!reset_s)
                    $fell(phy_resp_act) |-> $past(phy_resp_done))
      else begin
         $error("phy_resp_act fell without phy_resp_done");
         fail_count++;
      end

endmodule

bind sd_cmd_link sd_cmd_link_asserts sd_cmd_link_asserts_inst (
   .clk_50        (clk_50),
   .reset_s       (reset_s),
   .phy_resp_out  (phy_resp_out),
   .phy_resp_type (phy_resp_type),
   .phy_resp_act  (phy_resp_act),
   .phy_resp_done (phy_resp_done)
);

// ==== tb_sd_cmd_link.sv ====
// testbench: clock, reset, golden-file commands, PHY response handshake and checks
`timescale 1ns/1ps

module tb_sd_cmd_link;

   import sd_proto_pkg::*;

   localparam int MAX_VEC   = 64;
   localparam int WAIT_MAX  = 200;
   localparam int QUIET_LEN = 20;

   logic        clk_50;
   logic        reset_s;
   cmd_frame_t  phy_cmd_in;
   logic        phy_cmd_in_crc_good;
   logic        phy_cmd_in_act;
   resp_frame_t phy_resp_out;
   logic [3:0]  phy_resp_type;
   logic        phy_resp_act;
   logic        phy_resp_done;
   card_state_e link_card_state;
   cmd_index_t  cmd_in_last;
   logic        err_cmd_crc;
   logic        err_unhandled_cmd;

   // one command per entry, layout as in the golden file header
   logic [107:0] golden [MAX_VEC];
   int           errors;
   int           timeouts;
   int           checks;
   int           seed;

   sd_cmd_link #(
      .ACMD41_BUSY_POLLS (3),
      .RCA_STEP          (16'h1337)
   ) sd_cmd_link_inst (
      .clk_50, .reset_s, .phy_cmd_in, .phy_cmd_in_crc_good, .phy_cmd_in_act,
      .phy_resp_out, .phy_resp_type, .phy_resp_act, .phy_resp_done,
      .link_card_state, .cmd_in_last, .err_cmd_crc, .err_unhandled_cmd
   );

   initial begin
      clk_50 = 1'b0;
      forever #2 clk_50 = ~clk_50;
   end

   task automatic tick();
      @(posedge clk_50);
      #1;
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors++;
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
   endtask

   task automatic send_command(input cmd_index_t idx, input cmd_arg_t arg,
                               input logic crc_ok);
      // start 0, transmission 1, crc7 left at zero, end bit 1
      phy_cmd_in          = {2'b01, idx, arg, 7'h00, 1'b1};
      phy_cmd_in_crc_good = crc_ok;
      phy_cmd_in_act      = 1'b1;
      tick();
      tick();
      phy_cmd_in_act = 1'b0;
   endtask

   task automatic wait_resp_act(input logic level, input string what, output logic ok);
      int n;
      n = 0;
      while (phy_resp_act !== level && n < WAIT_MAX) begin
         tick();
         n++;
      end
      ok = (phy_resp_act === level);
      if (!ok) begin
         timeouts++;
         $display("timeout waiting for phy_resp_act to %s", what);
      end
   endtask

   initial begin
      logic [107:0] vec;
      cmd_index_t   idx;
      logic [47:0]  exp_top;
      logic [3:0]   exp_type;
      logic [3:0]   exp_state;
      logic [1:0]   exp_err;
      logic         ok;
      logic         seen;
      int           v;
      int           done_delay;
      int           assert_fails;

      reset_s             = 1'b0;
      phy_cmd_in          = '0;
      phy_cmd_in_crc_good = 1'b0;
      phy_cmd_in_act      = 1'b0;
      phy_resp_done       = 1'b0;
      errors              = 0;
      timeouts            = 0;
      checks              = 0;
      seed                = 49;
      $readmemh("sd_cmd_golden.txt", golden);
      repeat (8) @(posedge clk_50);
      #1;
      reset_s = 1'b1;
      tick();

      v = 0;
      while (v < MAX_VEC && golden[v][107:100] != 8'hFF && timeouts == 0) begin
         vec       = golden[v];
         idx       = vec[105:100];
         exp_type  = vec[59:56];
         exp_top   = vec[55:8];
         exp_state = vec[7:4];
         exp_err   = vec[1:0];
         send_command(idx, vec[99:68], vec[64]);
         if (vec[60]) begin
            wait_resp_act(1'b1, "rise", ok);
            if (ok) begin
               checks += 2;
               if (phy_resp_type != exp_type) begin
                  report_mismatch("phy_resp_type", phy_resp_type, exp_type);
               end
               if (phy_resp_out[135:88] != exp_top) begin
                  report_mismatch("phy_resp_out[135:88]", phy_resp_out[135:88], exp_top);
               end
               // PHY takes a few cycles to shift the response out
               done_delay = 2 + ($unsigned($random(seed)) % 3);
               repeat (done_delay) tick();
               phy_resp_done = 1'b1;
               wait_resp_act(1'b0, "fall", ok);
               phy_resp_done = 1'b0;
               tick();
               tick();
            end
         end else begin
            seen = 1'b0;
            for (int n = 0; n < QUIET_LEN; n++) begin
               tick();
               if (phy_resp_act) begin
                  seen = 1'b1;
               end
            end
            checks++;
            if (seen) begin
               errors++;
               $display("response raised for entry %0d where none was expected", v);
            end
         end
         checks += 3;
         if (link_card_state != exp_state) begin
            report_mismatch("link_card_state", link_card_state, exp_state);
         end
         if (err_cmd_crc != exp_err[0]) begin
            report_mismatch("err_cmd_crc", err_cmd_crc, exp_err[0]);
         end
         if (err_unhandled_cmd != exp_err[1]) begin
            report_mismatch("err_unhandled_cmd", err_unhandled_cmd, exp_err[1]);
         end
         if (vec[64] && cmd_in_last != idx) begin
            report_mismatch("cmd_in_last", cmd_in_last, idx);
         end
         v++;
      end

      if (v == 0) begin
         errors++;
         $display("no command entries were read from the golden file");
      end
      assert_fails = sd_cmd_link_inst.sd_cmd_link_asserts_inst.fail_count;
      $display("checks %0d errors %0d timeouts %0d assertion failures %0d",
               checks, errors, timeouts, assert_fails);
      if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== sd_cmd_golden.txt ====
// columns: index, argument, crc good, response expected, type, top 48 bits, state, error flags
// error flags: bit 0 err_cmd_crc, bit 1 err_unhandled_cmd. index FF ends the list
00_00000000_1_0_0_000000000000_0_0  // CMD0 go idle
08_000001AA_1_1_7_08000001AA01_0_0  // CMD8 echo 1AA
37_00000000_1_1_2_370000012001_0_0  // CMD55
29_40FF8000_1_1_5_3F40FF8000FF_0_0  // ACMD41 busy 1
37_00000000_1_1_2_370000012001_0_0  // CMD55
29_40FF8000_1_1_5_3F40FF8000FF_0_0  // ACMD41 busy 2
37_00000000_1_1_2_370000012001_0_0  // CMD55
29_40FF8000_1_1_5_3F40FF8000FF_0_0  // ACMD41 busy 3
37_00000000_1_1_2_370000012001_0_0  // CMD55
29_40FF8000_1_1_5_3FC0FF8000FF_1_0  // ACMD41 powered up
02_00000000_1_1_4_3F7E454D454D_2_0  // CMD2 CID
03_00000000_1_1_6_031337050001_3_0  // CMD3 new RCA
07_13370000_1_1_3_070000070001_4_0  // CMD7 select
0D_13370000_0_0_0_000000000000_4_1  // bad CRC frame
02_00000000_1_0_0_000000000000_4_1  // CMD2 illegal in TRAN
05_00000000_1_0_0_000000000000_4_3  // unknown index
37_13370000_1_1_2_370000092001_4_3  // CMD55 in TRAN
0D_13370000_1_1_2_0D0000092001_4_3  // ACMD13 retried as CMD13
0D_13370000_1_1_2_0D0000090001_4_3  // CMD13 app bit clear
07_00010000_1_0_0_000000000000_3_3  // CMD7 foreign RCA
0F_13370000_1_0_0_000000000000_9_3  // CMD15 inactive
00_00000000_1_0_0_000000000000_9_3  // CMD0 ignored in INA
FF_00000000_0_0_0_000000000000_0_0

// ==== filelist.f ====
sd_proto_pkg.sv
sd_card_pkg.sv
sd_cmd_capture.sv
sd_card_status.sv
sd_card_fsm.sv
sd_resp_builder.sv
sd_cmd_link.sv
sd_cmd_link_asserts.sv
tb_sd_cmd_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the SD command link testbench
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sd_cmd_link -Mdir obj_dir -o tb_sd_cmd_link \
   -f filelist.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sd_cmd_link > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
   echo "simulation passed"
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
